//--- src/rf_cfg_pkg.sv
/*
 * Sizing constants for the operand-fetch register file.
 * Import wherever a register count or data width is needed.
 */
package rf_cfg_pkg;

   // bits in a register number
   localparam int RF_ADDR_WIDTH = 5;

   // one register per address
   localparam int RF_WORDS = 2 ** RF_ADDR_WIDTH;

   // operand and result word
   localparam int OPERAND_WIDTH = 32;

endpackage

//--- src/rf_stage_pkg.sv
/*
 * Types shared by the register file, the destination tracker and the
 * bypass network. Describes the instruction in decode and the write-back
 * descriptor carried through the exec, ctrl and wb stages.
 */
package rf_stage_pkg;
   import rf_cfg_pkg::*;

   typedef logic [RF_ADDR_WIDTH-1:0] rf_adr_t;
   typedef logic [OPERAND_WIDTH-1:0] operand_t;

   // does the instruction write a register, and which one
   typedef struct packed {
      logic    we;
      rf_adr_t adr;
   } rf_dest_t;

   // instruction waiting in decode
   typedef struct packed {
      rf_adr_t  rfa_adr;
      rf_adr_t  rfb_adr;
      rf_dest_t dest;
   } decode_insn_t;

   // destinations of everything in flight past decode
   typedef struct packed {
      rf_dest_t exec;
      rf_dest_t ctrl;
      rf_dest_t wb;
   } stage_dests_t;

endpackage

//--- src/rf_ram.sv
/*
 * One copy of the register file: registered read with enable, one write
 * port. A read of the address being written returns the new word.
 * Registers never written since reset read as zero.
 */
`timescale 1ns/1ps

module rf_ram (
   input  logic                   clk,
   input  logic                   rst,
   input  rf_stage_pkg::rf_adr_t  rd_adr_i,
   input  logic                   rd_en_i,
   output rf_stage_pkg::operand_t rd_data_o,
   input  rf_stage_pkg::rf_adr_t  wr_adr_i,
   input  logic                   wr_en_i,
   input  rf_stage_pkg::operand_t wr_data_i
);
   import rf_cfg_pkg::*;
   import rf_stage_pkg::*;

   operand_t            mem [RF_WORDS];
   logic [RF_WORDS-1:0] written;

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_adr_i] <= wr_data_i;
      end
   end

   // tracks which entries hold real data since reset
   always_ff @(posedge clk) begin
      if (rst) begin
         written <= '0;
      end else if (wr_en_i) begin
         written[wr_adr_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         if (wr_en_i && (wr_adr_i == rd_adr_i)) begin
            rd_data_o <= wr_data_i;
         end else if (written[rd_adr_i]) begin
            rd_data_o <= mem[rd_adr_i];
         end else begin
            rd_data_o <= '0;
         end
      end
   end

   a_wr_adr_known : assert property (@(posedge clk) disable iff (rst)
      wr_en_i |-> !$isunknown(wr_adr_i))
      else $error("rf_ram: write with unknown address");

endmodule

//--- src/rf_dest_track.sv
/*
 * Moves each instruction's write-back descriptor from decode through
 * exec, ctrl and wb on every advance strobe. A flush squashes exec and
 * ctrl; the wb entry is older and still retires.
 */
`timescale 1ns/1ps

module rf_dest_track (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       padv_i,
   input  logic                       flush_i,
   input  rf_stage_pkg::rf_dest_t     decode_dest_i,
   output rf_stage_pkg::stage_dests_t dests_o
);
   import rf_stage_pkg::*;

   logic    exec_we;
   logic    ctrl_we;
   logic    wb_we;
   rf_adr_t exec_adr;
   rf_adr_t ctrl_adr;
   rf_adr_t wb_adr;

   // write enables, flush wins over advance
   always_ff @(posedge clk) begin
      if (rst) begin
         exec_we <= 1'b0;
         ctrl_we <= 1'b0;
         wb_we   <= 1'b0;
      end else if (flush_i) begin
         exec_we <= 1'b0;
         ctrl_we <= 1'b0;
      end else if (padv_i) begin
         exec_we <= decode_dest_i.we;
         ctrl_we <= exec_we;
         wb_we   <= ctrl_we;
      end
   end

   // register numbers only matter while the enable is set
   always_ff @(posedge clk) begin
      if (padv_i && !flush_i) begin
         exec_adr <= decode_dest_i.adr;
         ctrl_adr <= exec_adr;
         wb_adr   <= ctrl_adr;
      end
   end

   assign dests_o.exec.we  = exec_we;
   assign dests_o.exec.adr = exec_adr;
   assign dests_o.ctrl.we  = ctrl_we;
   assign dests_o.ctrl.adr = ctrl_adr;
   assign dests_o.wb.we    = wb_we;
   assign dests_o.wb.adr   = wb_adr;

   // the surrounding pipeline keeps these apart
   a_no_flush_on_adv : assert property (@(posedge clk) disable iff (rst)
      !(flush_i && padv_i))
      else $error("rf_dest_track: flush and advance in the same cycle");

endmodule

//--- src/rf_bypass.sv
/*
 * Register file with result forwarding. Hazards against the exec, ctrl
 * and wb destinations are registered on the advance strobe and pick the
 * operand source for the instruction entering exec. Two RAM copies give
 * the two read ports.
 */
`timescale 1ns/1ps

module rf_bypass (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       padv_i,
   input  logic                       flush_i,
   input  logic                       result_valid_i,
   input  rf_stage_pkg::rf_adr_t      rfa_adr_i,
   input  rf_stage_pkg::rf_adr_t      rfb_adr_i,
   input  rf_stage_pkg::stage_dests_t dests_i,
   input  rf_stage_pkg::operand_t     ctrl_result_i,
   input  rf_stage_pkg::operand_t     wb_result_i,
   output rf_stage_pkg::operand_t     rfa_o,
   output rf_stage_pkg::operand_t     rfb_o
);
   import rf_stage_pkg::*;

   logic       flushing;
   logic       exec_hazard_a;
   logic       exec_hazard_b;
   logic       ctrl_hazard_a;
   logic       ctrl_hazard_b;
   logic       ret_hazard_a;
   logic       ret_hazard_b;
   logic [2:0] sel_a;
   logic [2:0] sel_b;
   operand_t   ctrl_hold;
   operand_t   wb_hold;
   operand_t   ctrl_fwd;
   operand_t   wb_fwd;
   operand_t   ret_result;
   operand_t   ram_a;
   operand_t   ram_b;
   logic       rf_wr_en;

   // priority: ctrl result, then wb result, then retired value
   function automatic logic [2:0] fwd_sel(input logic from_ctrl, input logic from_wb,
                                          input logic from_ret);
      logic [2:0] sel;
      sel = 3'b000;
      if (from_ctrl) begin
         sel = 3'b100;
      end else if (from_wb) begin
         sel = 3'b010;
      end else if (from_ret) begin
         sel = 3'b001;
      end
      return sel;
   endfunction

   // and-or mux, relies on sel being one-hot or zero
   function automatic operand_t fwd_mux(input logic [2:0] sel, input operand_t ctrl_val,
                                        input operand_t wb_val, input operand_t ret_val,
                                        input operand_t ram_val);
      operand_t res;
      res = ram_val & {$bits(operand_t){~|sel}};
      res = res | (ctrl_val & {$bits(operand_t){sel[2]}});
      res = res | (wb_val & {$bits(operand_t){sel[1]}});
      res = res | (ret_val & {$bits(operand_t){sel[0]}});
      return res;
   endfunction

   // exec destination is stale after a flush until the next advance
   always_ff @(posedge clk) begin
      if (rst) begin
         flushing <= 1'b0;
      end else if (flush_i) begin
         flushing <= 1'b1;
      end else if (padv_i) begin
         flushing <= 1'b0;
      end
   end

   // compare against the stages as they stand before the shift
   always_ff @(posedge clk) begin
      if (rst) begin
         exec_hazard_a <= 1'b0;
         exec_hazard_b <= 1'b0;
      end else if (flush_i) begin
         exec_hazard_a <= 1'b0;
         exec_hazard_b <= 1'b0;
      end else if (padv_i && !flushing) begin
         exec_hazard_a <= dests_i.exec.we && (dests_i.exec.adr == rfa_adr_i);
         exec_hazard_b <= dests_i.exec.we && (dests_i.exec.adr == rfb_adr_i);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_hazard_a <= 1'b0;
         ctrl_hazard_b <= 1'b0;
         ret_hazard_a  <= 1'b0;
         ret_hazard_b  <= 1'b0;
      end else if (padv_i) begin
         ctrl_hazard_a <= dests_i.ctrl.we && (dests_i.ctrl.adr == rfa_adr_i);
         ctrl_hazard_b <= dests_i.ctrl.we && (dests_i.ctrl.adr == rfb_adr_i);
         ret_hazard_a  <= dests_i.wb.we && (dests_i.wb.adr == rfa_adr_i);
         ret_hazard_b  <= dests_i.wb.we && (dests_i.wb.adr == rfb_adr_i);
      end
   end

   // keep the last valid results while result_valid_i is low
   always_ff @(posedge clk) begin
      if (result_valid_i) begin
         ctrl_hold <= ctrl_result_i;
         wb_hold   <= wb_result_i;
      end
   end

   assign ctrl_fwd = result_valid_i ? ctrl_result_i : ctrl_hold;
   assign wb_fwd   = result_valid_i ? wb_result_i : wb_hold;

   // value of the instruction retiring at this advance
   always_ff @(posedge clk) begin
      if (rst) begin
         ret_result <= '0;
      end else if (padv_i) begin
         ret_result <= wb_fwd;
      end
   end

   assign sel_a = fwd_sel(exec_hazard_a, ctrl_hazard_a, ret_hazard_a);
   assign sel_b = fwd_sel(exec_hazard_b, ctrl_hazard_b, ret_hazard_b);

   assign rfa_o = fwd_mux(sel_a, ctrl_fwd, wb_fwd, ret_result, ram_a);
   assign rfb_o = fwd_mux(sel_b, ctrl_fwd, wb_fwd, ret_result, ram_b);

   // wb entry writes as it leaves the pipeline
   assign rf_wr_en = padv_i && dests_i.wb.we;

   rf_ram u_ram_a (
      .clk       (clk),
      .rst       (rst),
      .rd_adr_i  (rfa_adr_i),
      .rd_en_i   (padv_i),
      .rd_data_o (ram_a),
      .wr_adr_i  (dests_i.wb.adr),
      .wr_en_i   (rf_wr_en),
      .wr_data_i (wb_fwd)
   );

   rf_ram u_ram_b (
      .clk       (clk),
      .rst       (rst),
      .rd_adr_i  (rfb_adr_i),
      .rd_en_i   (padv_i),
      .rd_data_o (ram_b),
      .wr_adr_i  (dests_i.wb.adr),
      .wr_en_i   (rf_wr_en),
      .wr_data_i (wb_fwd)
   );

   // hold registers have no reset, a retiring word must still be known
   a_wr_data_known : assert property (@(posedge clk) disable iff (rst)
      rf_wr_en |-> !$isunknown(wb_fwd))
      else $error("rf_bypass: retiring write with unknown data");

endmodule

//--- src/rf_top.sv
/*
 * Operand-fetch block: destination tracker plus the forwarding register
 * file. Drive one advance strobe per pipeline step; operands are valid
 * from the cycle after the strobe until the next one.
 */
`timescale 1ns/1ps

module rf_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       padv_i,
   input  logic                       flush_i,
   input  logic                       result_valid_i,
   input  rf_stage_pkg::decode_insn_t decode_i,
   input  rf_stage_pkg::operand_t     ctrl_result_i,
   input  rf_stage_pkg::operand_t     wb_result_i,
   output rf_stage_pkg::operand_t     rfa_o,
   output rf_stage_pkg::operand_t     rfb_o
);
   import rf_stage_pkg::*;

   stage_dests_t dests;

   rf_dest_track u_track (
      .clk           (clk),
      .rst           (rst),
      .padv_i        (padv_i),
      .flush_i       (flush_i),
      .decode_dest_i (decode_i.dest),
      .dests_o       (dests)
   );

   rf_bypass u_bypass (
      .clk            (clk),
      .rst            (rst),
      .padv_i         (padv_i),
      .flush_i        (flush_i),
      .result_valid_i (result_valid_i),
      .rfa_adr_i      (decode_i.rfa_adr),
      .rfb_adr_i      (decode_i.rfb_adr),
      .dests_i        (dests),
      .ctrl_result_i  (ctrl_result_i),
      .wb_result_i    (wb_result_i),
      .rfa_o          (rfa_o),
      .rfb_o          (rfb_o)
   );

endmodule

//--- sim/rf_tb.sv
/*
 * Testbench for the operand-fetch block. Plays decode, execute and
 * write-back around rf_top with a seeded random instruction stream,
 * keeps a reference model of the registers and the stages, and checks
 * the operands with concurrent assertions.
 */
`timescale 1ns/1ps

module rf_tb;
   import rf_cfg_pkg::*;
   import rf_stage_pkg::*;

   localparam int          CLK_PERIOD      = 8;
   localparam int          RESET_CYCLES    = 4;
   localparam int          NUM_INSNS       = 400;
   localparam int          WATCHDOG_CYCLES = NUM_INSNS * 4 + 100;
   localparam logic [31:0] SEED            = 32'hc0fba4e3;
   // registers 0..5 only, keeps hazards frequent
   localparam int          MAX_REG         = 5;

   // model entry for one stage
   typedef struct packed {
      logic     we;
      rf_adr_t  adr;
      operand_t res;
   } model_stage_t;

   logic         clk;
   logic         rst;
   logic         padv;
   logic         flush;
   logic         result_valid;
   decode_insn_t decode_insn;
   operand_t     ctrl_result;
   operand_t     wb_result;
   operand_t     rfa;
   operand_t     rfb;

   // reference model
   operand_t     arch_regs [RF_WORDS];
   model_stage_t exec_m;
   model_stage_t ctrl_m;
   model_stage_t wb_m;
   decode_insn_t dec_m;
   int unsigned  dec_seq;

   // expected operands of the instruction in exec
   operand_t     exp_rfa;
   operand_t     exp_rfb;
   logic         check_en;
   logic         same_step;
   operand_t     prev_rfa;
   operand_t     prev_rfb;
   int           flush_count;

   rf_top u_dut (
      .clk            (clk),
      .rst            (rst),
      .padv_i         (padv),
      .flush_i        (flush),
      .result_valid_i (result_valid),
      .decode_i       (decode_insn),
      .ctrl_result_i  (ctrl_result),
      .wb_result_i    (wb_result),
      .rfa_o          (rfa),
      .rfb_o          (rfb)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   // result of an instruction, a mix of its sequence number
   function automatic operand_t insn_result(input int unsigned seq);
      return (seq * 32'h9e3779b1) ^ 32'h5bd1e995;
   endfunction

   // youngest older writer wins, else the architectural value
   function automatic operand_t expected_operand(input rf_adr_t src);
      operand_t val;
      val = arch_regs[src];
      if (ctrl_m.we && (ctrl_m.adr == src)) begin
         val = ctrl_m.res;
      end
      if (exec_m.we && (exec_m.adr == src)) begin
         val = exec_m.res;
      end
      return val;
   endfunction

   function automatic decode_insn_t random_insn();
      decode_insn_t insn;
      insn.rfa_adr  = rf_adr_t'($urandom_range(0, MAX_REG));
      insn.rfb_adr  = rf_adr_t'($urandom_range(0, MAX_REG));
      insn.dest.we  = ($urandom_range(0, 9) < 8);
      insn.dest.adr = rf_adr_t'($urandom_range(0, MAX_REG));
      return insn;
   endfunction

   // retire wb, pick operands, then shift decode into exec
   task automatic advance_model(output operand_t op_a, output operand_t op_b);
      if (wb_m.we) begin
         arch_regs[wb_m.adr] = wb_m.res;
      end
      op_a = expected_operand(dec_m.rfa_adr);
      op_b = expected_operand(dec_m.rfb_adr);
      wb_m       = ctrl_m;
      ctrl_m     = exec_m;
      exec_m.we  = dec_m.dest.we;
      exec_m.adr = dec_m.dest.adr;
      exec_m.res = insn_result(dec_seq);
      dec_m      = random_insn();
      dec_seq    = dec_seq + 1;
   endtask

   task automatic squash_stages();
      exec_m.we = 1'b0;
      ctrl_m.we = 1'b0;
   endtask

   always @(posedge clk) begin
      prev_rfa <= rfa;
      prev_rfb <= rfb;
   end

   a_rfa_value : assert property (@(posedge clk) disable iff (rst)
      check_en |-> (rfa == exp_rfa))
      else stop_on_error($sformatf("FAILED t=%0t rfa_o expected %h actual %h",
                                   $time, $sampled(exp_rfa), $sampled(rfa)));

   a_rfb_value : assert property (@(posedge clk) disable iff (rst)
      check_en |-> (rfb == exp_rfb))
      else stop_on_error($sformatf("FAILED t=%0t rfb_o expected %h actual %h",
                                   $time, $sampled(exp_rfb), $sampled(rfb)));

   // operands hold while padv is low
   a_rfa_stall : assert property (@(posedge clk) disable iff (rst)
      same_step |-> (rfa == prev_rfa))
      else stop_on_error($sformatf("FAILED t=%0t rfa_o expected %h actual %h",
                                   $time, $sampled(prev_rfa), $sampled(rfa)));

   a_rfb_stall : assert property (@(posedge clk) disable iff (rst)
      same_step |-> (rfb == prev_rfb))
      else stop_on_error($sformatf("FAILED t=%0t rfb_o expected %h actual %h",
                                   $time, $sampled(prev_rfb), $sampled(rfb)));

   initial begin : stimulus
      int unsigned seed_draw;
      int          adv_count;
      int          idle_left;
      int          tail;
      logic        adv_next;
      logic        flush_next;
      logic        valid_next;
      operand_t    op_a;
      operand_t    op_b;

      seed_draw = $urandom(SEED);
      rst          <= 1'b1;
      padv         <= 1'b0;
      flush        <= 1'b0;
      result_valid <= 1'b1;
      ctrl_result  <= '0;
      wb_result    <= '0;
      decode_insn  <= '0;
      check_en     <= 1'b0;
      same_step    <= 1'b0;
      for (int i = 0; i < RF_WORDS; i++) begin
         arch_regs[i] = '0;
      end
      exec_m      = '0;
      ctrl_m      = '0;
      wb_m        = '0;
      dec_seq     = 0;
      dec_m       = random_insn();
      flush_count = 0;
      adv_count   = 0;
      tail        = 3;
      idle_left   = $urandom_range(0, 2);

      repeat (RESET_CYCLES) @(posedge clk);
      rst         <= 1'b0;
      decode_insn <= dec_m;

      while ((adv_count < NUM_INSNS) || (tail > 0)) begin
         @(posedge clk);
         // react to what the DUT sampled at this edge
         if (padv) begin
            advance_model(op_a, op_b);
            exp_rfa  <= op_a;
            exp_rfb  <= op_b;
            check_en <= 1'b1;
         end else if (flush) begin
            squash_stages();
            check_en    <= 1'b0;
            flush_count = flush_count + 1;
         end
         // stalls after a flush hold the operands too
         same_step <= (dec_seq > 0) && !padv && !flush;

         if (adv_count == NUM_INSNS) begin
            adv_next   = 1'b0;
            flush_next = 1'b0;
            tail       = tail - 1;
         end else if (idle_left > 0) begin
            adv_next   = 1'b0;
            flush_next = ($urandom_range(0, 11) == 0);
            idle_left  = idle_left - 1;
         end else begin
            adv_next   = 1'b1;
            flush_next = 1'b0;
            idle_left  = $urandom_range(0, 2);
            adv_count  = adv_count + 1;
         end

         // fresh results must be valid right after an advance
         valid_next = padv || ($urandom_range(0, 3) != 0);
         padv         <= adv_next;
         flush        <= flush_next;
         result_valid <= valid_next;
         ctrl_result  <= valid_next ? ctrl_m.res : operand_t'($urandom);
         wb_result    <= valid_next ? wb_m.res : operand_t'($urandom);
         decode_insn  <= dec_m;
      end

      @(negedge clk);
      $display("%0d instructions, %0d flushes", NUM_INSNS, flush_count);
      $display("TEST RESULT: PASS");
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      stop_on_error($sformatf("timeout: run did not finish within %0d clock cycles",
                              WATCHDOG_CYCLES));
   end

endmodule

//--- list.f
src/rf_cfg_pkg.sv
src/rf_stage_pkg.sv
src/rf_ram.sv
src/rf_dest_track.sv
src/rf_bypass.sv
src/rf_top.sv
sim/rf_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the operand-fetch testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
   -f list.f --top-module rf_tb

# the log decides the result
./obj_dir/Vrf_tb 2>&1 | tee "$LOG" || true

if grep -q "TEST RESULT: FAIL" "$LOG"; then
   echo "simulation failed, see $LOG"
   exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
   echo "simulation ended without a result line, see $LOG"
   exit 1
fi
echo "simulation passed"
